//--- rtl/axi_burst_if.sv
`timescale 1ns/1ps
`default_nettype none

interface axi_burst_if #(
  parameter int DATA_W = 64,
  parameter int BEATS  = 4
);

  localparam int LINE_W = DATA_W * BEATS;
  // counter width from beats per line
  localparam int LEN_W  = (LINE_W / DATA_W > 1) ? $clog2(LINE_W / DATA_W) : 1;

  logic                              start;
  logic [axi_rw_pkg::AXI_ADDR_W-1:0] addr;
  logic [LEN_W-1:0]                  len;
  logic                              done;
  axi_rw_pkg::axi_resp_e             resp;

  modport ctrl_mp (
    output start,
    output addr,
    output len,
    input  done,
    input  resp
  );

  modport chan_mp (
    input  start,
    input  addr,
    input  len,
    output done,
    output resp
  );

endinterface

`default_nettype wire

//--- rtl/axi_rd_chan.sv
`timescale 1ns/1ps
`default_nettype none

module axi_rd_chan #(
  parameter int DATA_W = 64,
  parameter int BEATS  = 4,
  parameter int AXI_ID = 0
) (
  input  wire                               clock,
  input  wire                               rst_n_i,
  axi_burst_if.chan_mp                      bus,
  output logic [DATA_W*BEATS-1:0]           line_o,
  input  wire                               io_master_arready_i,
  output logic                              io_master_arvalid_o,
  output logic [axi_rw_pkg::AXI_ADDR_W-1:0] io_master_araddr_o,
  output logic [3:0]                        io_master_arid_o,
  output logic [7:0]                        io_master_arlen_o,
  output logic [2:0]                        io_master_arsize_o,
  output logic [1:0]                        io_master_arburst_o,
  output logic                              io_master_rready_o,
  input  wire                               io_master_rvalid_i,
  input  wire [1:0]                         io_master_rresp_i,
  input  wire [DATA_W-1:0]                  io_master_rdata_i,
  input  wire                               io_master_rlast_i
);

  localparam int LINE_W = DATA_W * BEATS;
  localparam int LEN_W  = (BEATS > 1) ? $clog2(BEATS) : 1;
  localparam logic [2:0] AX_SIZE = 3'($clog2(DATA_W / 8));

  logic                              ar_valid_q;
  logic                              r_ready_q;
  logic                              done_q;
  logic [axi_rw_pkg::AXI_ADDR_W-1:0] addr_q;
  logic [LEN_W-1:0]                  len_q;
  logic [LEN_W-1:0]                  beat_q;
  logic [LINE_W-1:0]                 line_q;
  axi_rw_pkg::axi_resp_e             resp_q;
  logic                              r_fire;

  assign r_fire = r_ready_q && io_master_rvalid_i;

  //////////////////////////////////////////////////
  // handshake state
  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ar_valid_q <= 1'b0;
      r_ready_q  <= 1'b0;
      done_q     <= 1'b0;
      beat_q     <= '0;
    end else begin
      done_q <= 1'b0;
      if (bus.start) begin
        ar_valid_q <= 1'b1;
        beat_q     <= '0;
      end else begin
        if (ar_valid_q && io_master_arready_i) begin
          ar_valid_q <= 1'b0;
          r_ready_q  <= 1'b1;
        end
        if (r_fire) begin
          beat_q <= beat_q + 1'b1;
          if (io_master_rlast_i) begin
            r_ready_q <= 1'b0;
            done_q    <= 1'b1;
          end
        end
      end
    end
  end

  // unused beats stay zero, first error response sticks
  always_ff @(posedge clock) begin
    if (bus.start) begin
      addr_q <= bus.addr;
      len_q  <= bus.len;
      line_q <= '0;
      resp_q <= axi_rw_pkg::RESP_OKAY;
    end else if (r_fire) begin
      line_q[beat_q*DATA_W +: DATA_W] <= io_master_rdata_i;
      if (resp_q == axi_rw_pkg::RESP_OKAY) begin
        resp_q <= axi_rw_pkg::axi_resp_e'(io_master_rresp_i);
      end
    end
  end

  assign io_master_arvalid_o = ar_valid_q;
  assign io_master_araddr_o  = addr_q;
  assign io_master_arid_o    = 4'(AXI_ID);
  assign io_master_arlen_o   = 8'(len_q);
  assign io_master_arsize_o  = AX_SIZE;
  assign io_master_arburst_o = axi_rw_pkg::BURST_INCR;
  assign io_master_rready_o  = r_ready_q;

  assign line_o   = line_q;
  assign bus.done = done_q;
  assign bus.resp = resp_q;

endmodule

`default_nettype wire

//--- rtl/axi_rw_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module axi_rw_ctrl #(
  parameter int BEATS = 4
) (
  input  wire                              clock,
  input  wire                              rst_n_i,
  input  wire                              user_valid_i,
  input  wire axi_rw_pkg::req_op_e         user_op_i,
  input  wire [axi_rw_pkg::AXI_ADDR_W-1:0] user_addr_i,
  input  wire [7:0]                        user_blks_i,
  output logic                             user_ready_o,
  output axi_rw_pkg::axi_resp_e            user_resp_o,
  axi_burst_if.ctrl_mp                     wr_mp,
  axi_burst_if.ctrl_mp                     rd_mp
);

  localparam int LEN_W = (BEATS > 1) ? $clog2(BEATS) : 1;

  axi_rw_pkg::ctrl_state_e           state_q;
  logic                              wr_start_q;
  logic                              rd_start_q;
  logic [axi_rw_pkg::AXI_ADDR_W-1:0] addr_q;
  logic [LEN_W-1:0]                  len_q;
  logic [7:0]                        blks_clamp;
  logic                              accept;

  assign accept     = (state_q == axi_rw_pkg::ST_IDLE) && user_valid_i;
  // never ask for more beats than a line holds
  assign blks_clamp = (user_blks_i > 8'(BEATS - 1)) ? 8'(BEATS - 1) : user_blks_i;

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= axi_rw_pkg::ST_IDLE;
      wr_start_q  <= 1'b0;
      rd_start_q  <= 1'b0;
      user_resp_o <= axi_rw_pkg::RESP_OKAY;
    end else begin
      wr_start_q <= 1'b0;
      rd_start_q <= 1'b0;
      case (state_q)
        axi_rw_pkg::ST_IDLE: begin
          if (accept) begin
            if (user_op_i == axi_rw_pkg::REQ_WRITE) begin
              state_q    <= axi_rw_pkg::ST_WRITE;
              wr_start_q <= 1'b1;
            end else begin
              state_q    <= axi_rw_pkg::ST_READ;
              rd_start_q <= 1'b1;
            end
          end
        end
        axi_rw_pkg::ST_WRITE: begin
          if (wr_mp.done) begin
            state_q     <= axi_rw_pkg::ST_DONE;
            user_resp_o <= wr_mp.resp;
          end
        end
        axi_rw_pkg::ST_READ: begin
          if (rd_mp.done) begin
            state_q     <= axi_rw_pkg::ST_DONE;
            user_resp_o <= rd_mp.resp;
          end
        end
        default: state_q <= axi_rw_pkg::ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      addr_q <= user_addr_i;
      len_q  <= LEN_W'(blks_clamp);
    end
  end

  assign user_ready_o = (state_q == axi_rw_pkg::ST_DONE);

  assign wr_mp.start = wr_start_q;
  assign wr_mp.addr  = addr_q;
  assign wr_mp.len   = len_q;
  assign rd_mp.start = rd_start_q;
  assign rd_mp.addr  = addr_q;
  assign rd_mp.len   = len_q;

endmodule

`default_nettype wire

//--- rtl/axi_rw_pkg.sv
`default_nettype none

package axi_rw_pkg;

  localparam int AXI_ADDR_W = 32;

  localparam logic [1:0] BURST_INCR = 2'b01;

  typedef enum logic {
    REQ_READ  = 1'b0,
    REQ_WRITE = 1'b1
  } req_op_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

  // one request in flight, done lasts a single cycle
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_WRITE = 2'd1,
    ST_READ  = 2'd2,
    ST_DONE  = 2'd3
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- rtl/axi_rw_top.sv
`timescale 1ns/1ps
`default_nettype none

module axi_rw_top #(
  parameter int DATA_W = 64,
  parameter int BEATS  = 4,
  parameter int AXI_ID = 0
) (
  input  wire                               clock,
  input  wire                               rst_n_i,
  // user side
  input  wire                               user_valid_i,
  input  wire axi_rw_pkg::req_op_e          user_op_i,
  input  wire [axi_rw_pkg::AXI_ADDR_W-1:0]  user_addr_i,
  input  wire [7:0]                         user_blks_i,
  input  wire [DATA_W*BEATS-1:0]            user_wdata_i,
  output logic                              user_ready_o,
  output logic [DATA_W*BEATS-1:0]           user_rdata_o,
  output axi_rw_pkg::axi_resp_e             user_resp_o,
  // axi write
  input  wire                               io_master_awready_i,
  output logic                              io_master_awvalid_o,
  output logic [axi_rw_pkg::AXI_ADDR_W-1:0] io_master_awaddr_o,
  output logic [3:0]                        io_master_awid_o,
  output logic [7:0]                        io_master_awlen_o,
  output logic [2:0]                        io_master_awsize_o,
  output logic [1:0]                        io_master_awburst_o,
  input  wire                               io_master_wready_i,
  output logic                              io_master_wvalid_o,
  output logic [DATA_W-1:0]                 io_master_wdata_o,
  output logic [DATA_W/8-1:0]               io_master_wstrb_o,
  output logic                              io_master_wlast_o,
  output logic                              io_master_bready_o,
  input  wire                               io_master_bvalid_i,
  input  wire [1:0]                         io_master_bresp_i,
  // axi read
  input  wire                               io_master_arready_i,
  output logic                              io_master_arvalid_o,
  output logic [axi_rw_pkg::AXI_ADDR_W-1:0] io_master_araddr_o,
  output logic [3:0]                        io_master_arid_o,
  output logic [7:0]                        io_master_arlen_o,
  output logic [2:0]                        io_master_arsize_o,
  output logic [1:0]                        io_master_arburst_o,
  output logic                              io_master_rready_o,
  input  wire                               io_master_rvalid_i,
  input  wire [1:0]                         io_master_rresp_i,
  input  wire [DATA_W-1:0]                  io_master_rdata_i,
  input  wire                               io_master_rlast_i
);

  axi_burst_if #(.DATA_W(DATA_W), .BEATS(BEATS)) wr_bus ();
  axi_burst_if #(.DATA_W(DATA_W), .BEATS(BEATS)) rd_bus ();

  axi_rw_ctrl #(.BEATS(BEATS)) u_ctrl (
    .wr_mp (wr_bus),
    .rd_mp (rd_bus),
    .*
  );

  // channel ports carry the top level names
  axi_wr_chan #(.DATA_W(DATA_W), .BEATS(BEATS), .AXI_ID(AXI_ID)) u_wr_chan (
    .bus    (wr_bus),
    .line_i (user_wdata_i),
    .*
  );

  axi_rd_chan #(.DATA_W(DATA_W), .BEATS(BEATS), .AXI_ID(AXI_ID)) u_rd_chan (
    .bus    (rd_bus),
    .line_o (user_rdata_o),
    .*
  );

endmodule

`default_nettype wire

//--- rtl/axi_wr_chan.sv
`timescale 1ns/1ps
`default_nettype none

module axi_wr_chan #(
  parameter int DATA_W = 64,
  parameter int BEATS  = 4,
  parameter int AXI_ID = 0
) (
  input  wire                               clock,
  input  wire                               rst_n_i,
  axi_burst_if.chan_mp                      bus,
  input  wire [DATA_W*BEATS-1:0]            line_i,
  input  wire                               io_master_awready_i,
  output logic                              io_master_awvalid_o,
  output logic [axi_rw_pkg::AXI_ADDR_W-1:0] io_master_awaddr_o,
  output logic [3:0]                        io_master_awid_o,
  output logic [7:0]                        io_master_awlen_o,
  output logic [2:0]                        io_master_awsize_o,
  output logic [1:0]                        io_master_awburst_o,
  input  wire                               io_master_wready_i,
  output logic                              io_master_wvalid_o,
  output logic [DATA_W-1:0]                 io_master_wdata_o,
  output logic [DATA_W/8-1:0]               io_master_wstrb_o,
  output logic                              io_master_wlast_o,
  output logic                              io_master_bready_o,
  input  wire                               io_master_bvalid_i,
  input  wire [1:0]                         io_master_bresp_i
);

  localparam int LINE_W = DATA_W * BEATS;
  localparam int LEN_W  = (BEATS > 1) ? $clog2(BEATS) : 1;
  localparam logic [2:0] AX_SIZE = 3'($clog2(DATA_W / 8));

  logic                              aw_valid_q;
  logic                              w_valid_q;
  logic                              b_ready_q;
  logic                              done_q;
  logic [axi_rw_pkg::AXI_ADDR_W-1:0] addr_q;
  logic [LEN_W-1:0]                  len_q;
  logic [LEN_W-1:0]                  beat_q;
  logic [LINE_W-1:0]                 line_q;
  axi_rw_pkg::axi_resp_e             resp_q;
  logic                              w_fire;
  logic                              b_fire;
  logic                              w_final;

  assign w_fire  = w_valid_q && io_master_wready_i;
  assign b_fire  = b_ready_q && io_master_bvalid_i;
  assign w_final = (beat_q == len_q);

  //////////////////////////////////////////////////
  // handshake state
  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      aw_valid_q <= 1'b0;
      w_valid_q  <= 1'b0;
      b_ready_q  <= 1'b0;
      done_q     <= 1'b0;
      beat_q     <= '0;
    end else begin
      done_q <= 1'b0;
      if (bus.start) begin
        aw_valid_q <= 1'b1;
        w_valid_q  <= 1'b1;
        beat_q     <= '0;
      end else begin
        if (aw_valid_q && io_master_awready_i) begin
          aw_valid_q <= 1'b0;
        end
        if (w_fire) begin
          if (w_final) begin
            w_valid_q <= 1'b0;
            b_ready_q <= 1'b1;
          end else begin
            beat_q <= beat_q + 1'b1;
          end
        end
        if (b_fire) begin
          b_ready_q <= 1'b0;
          done_q    <= 1'b1;
        end
      end
    end
  end

  // line shifts down one beat per accepted W
  always_ff @(posedge clock) begin
    if (bus.start) begin
      addr_q <= bus.addr;
      len_q  <= bus.len;
      line_q <= line_i;
    end else if (w_fire) begin
      line_q <= line_q >> DATA_W;
    end
    if (b_fire) begin
      resp_q <= axi_rw_pkg::axi_resp_e'(io_master_bresp_i);
    end
  end

  //////////////////////////////////////////////////
  // outputs
  assign io_master_awvalid_o = aw_valid_q;
  assign io_master_awaddr_o  = addr_q;
  assign io_master_awid_o    = 4'(AXI_ID);
  assign io_master_awlen_o   = 8'(len_q);
  assign io_master_awsize_o  = AX_SIZE;
  assign io_master_awburst_o = axi_rw_pkg::BURST_INCR;
  assign io_master_wvalid_o  = w_valid_q;
  assign io_master_wdata_o   = line_q[DATA_W-1:0];
  assign io_master_wstrb_o   = '1;
  assign io_master_wlast_o   = w_valid_q && w_final;
  assign io_master_bready_o  = b_ready_q;

  assign bus.done = done_q;
  assign bus.resp = resp_q;

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_axi_rw -f tb.f -o sim_axi_rw
out=$(./obj_dir/sim_axi_rw 2>&1) || true
echo "$out"
if echo "$out" | grep -qx "TEST PASS"; then
  exit 0
fi
exit 1

//--- tb.f
rtl/axi_rw_pkg.sv
rtl/axi_burst_if.sv
rtl/axi_rw_ctrl.sv
rtl/axi_wr_chan.sv
rtl/axi_rd_chan.sv
rtl/axi_rw_top.sv
tests/axi_rw_sva.sv
tests/tb_axi_rw.sv

//--- tests/axi_rw_sva.sv
`timescale 1ns/1ps
`default_nettype none

module axi_rw_sva #(
  parameter int DATA_W = 64
) (
  input wire              clock,
  input wire              rst_n_i,
  input wire              awvalid_i,
  input wire              awready_i,
  input wire [31:0]       awaddr_i,
  input wire [7:0]        awlen_i,
  input wire              wvalid_i,
  input wire              wready_i,
  input wire [DATA_W-1:0] wdata_i,
  input wire              wlast_i,
  input wire              arvalid_i,
  input wire              arready_i,
  input wire [31:0]       araddr_i,
  input wire [7:0]        arlen_i,
  input wire              user_ready_i
);

  int unsigned fail_cnt = 0;

  // valid and payload hold until ready
  aw_hold: assert property (@(posedge clock) disable iff (!rst_n_i)
    awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i) && $stable(awlen_i))
    else begin
      fail_cnt++;
      $error("awvalid or AW payload changed before awready");
    end

  w_hold: assert property (@(posedge clock) disable iff (!rst_n_i)
    wvalid_i && !wready_i |=> wvalid_i && $stable(wdata_i) && $stable(wlast_i))
    else begin
      fail_cnt++;
      $error("wvalid or W payload changed before wready");
    end

  ar_hold: assert property (@(posedge clock) disable iff (!rst_n_i)
    arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i) && $stable(arlen_i))
    else begin
      fail_cnt++;
      $error("arvalid or AR payload changed before arready");
    end

  // completion is a single cycle pulse
  ready_pulse: assert property (@(posedge clock) disable iff (!rst_n_i)
    user_ready_i |=> !user_ready_i)
    else begin
      fail_cnt++;
      $error("user_ready_o held longer than one cycle");
    end

endmodule

bind axi_rw_top axi_rw_sva #(.DATA_W(DATA_W)) sva_i (
  .clock        (clock),
  .rst_n_i      (rst_n_i),
  .awvalid_i    (io_master_awvalid_o),
  .awready_i    (io_master_awready_i),
  .awaddr_i     (io_master_awaddr_o),
  .awlen_i      (io_master_awlen_o),
  .wvalid_i     (io_master_wvalid_o),
  .wready_i     (io_master_wready_i),
  .wdata_i      (io_master_wdata_o),
  .wlast_i      (io_master_wlast_o),
  .arvalid_i    (io_master_arvalid_o),
  .arready_i    (io_master_arready_i),
  .araddr_i     (io_master_araddr_o),
  .arlen_i      (io_master_arlen_o),
  .user_ready_i (user_ready_o)
);

`default_nettype wire

//--- tests/tb_axi_rw.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_rw;

  localparam int DATA_W     = 64;
  localparam int BEATS      = 4;
  localparam int AXI_ID     = 5;
  localparam int LINE_W     = DATA_W * BEATS;
  localparam int LINE_BYTES = LINE_W / 8;
  localparam int MEM_BEATS  = 64;
  localparam int N_LINES    = MEM_BEATS / BEATS;
  // top 8 beats of the slave answer with SLVERR
  localparam int ERR_BASE   = MEM_BEATS - 8;
  localparam int ERR_LINE   = ERR_BASE / BEATS;
  localparam int N_PAIRS    = 24;
  localparam int N_REQ      = 2 * N_PAIRS + 4;

  typedef logic [LINE_W-1:0] line_t;

  logic                  clock;
  logic                  rst_n_i;
  logic                  user_valid_i;
  axi_rw_pkg::req_op_e   user_op_i;
  logic [31:0]           user_addr_i;
  logic [7:0]            user_blks_i;
  line_t                 user_wdata_i;
  logic                  user_ready_o;
  line_t                 user_rdata_o;
  axi_rw_pkg::axi_resp_e user_resp_o;
  logic                  io_master_awready_i;
  logic                  io_master_awvalid_o;
  logic [31:0]           io_master_awaddr_o;
  logic [3:0]            io_master_awid_o;
  logic [7:0]            io_master_awlen_o;
  logic [2:0]            io_master_awsize_o;
  logic [1:0]            io_master_awburst_o;
  logic                  io_master_wready_i;
  logic                  io_master_wvalid_o;
  logic [DATA_W-1:0]     io_master_wdata_o;
  logic [DATA_W/8-1:0]   io_master_wstrb_o;
  logic                  io_master_wlast_o;
  logic                  io_master_bready_o;
  logic                  io_master_bvalid_i;
  logic [1:0]            io_master_bresp_i;
  logic                  io_master_arready_i;
  logic                  io_master_arvalid_o;
  logic [31:0]           io_master_araddr_o;
  logic [3:0]            io_master_arid_o;
  logic [7:0]            io_master_arlen_o;
  logic [2:0]            io_master_arsize_o;
  logic [1:0]            io_master_arburst_o;
  logic                  io_master_rready_o;
  logic                  io_master_rvalid_i;
  logic [1:0]            io_master_rresp_i;
  logic [DATA_W-1:0]     io_master_rdata_i;
  logic                  io_master_rlast_i;

  int                seed = 45291;
  int                n_checks = 0;
  int                n_errors = 0;
  int                n_req = 0;
  int                n_pulses = 0;
  line_t             ref_mem [N_LINES];
  logic [DATA_W-1:0] slv_mem [MEM_BEATS];
  logic [31:0]       last_awaddr;
  logic [31:0]       last_araddr;
  int                last_awlen;
  int                last_arlen;

  axi_rw_top #(.DATA_W(DATA_W), .BEATS(BEATS), .AXI_ID(AXI_ID)) dut_i (.*);

  initial clock = 1'b0;
  always #10 clock = ~clock;

  always @(negedge clock) begin
    if (rst_n_i && user_ready_o) begin
      n_pulses++;
    end
  end

  //////////////////////////////////////////////////
  // compare tasks
  task automatic check_line(input string name, input line_t exp, input line_t got);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("mismatch %s: expected %h got %h", name, exp, got);
    end
  endtask

  task automatic check_resp(input string name, input axi_rw_pkg::axi_resp_e exp,
                            input axi_rw_pkg::axi_resp_e got);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("mismatch %s: expected %h got %h", name, exp, got);
    end
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("mismatch %s: expected %h got %h", name, exp, got);
    end
  endtask

  task automatic report_test(input string name);
    $display("test %-20s done, errors so far %0d", name, n_errors);
  endtask

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic int beat_index(input logic [31:0] addr);
    return int'(addr / 32'(DATA_W / 8)) % MEM_BEATS;
  endfunction

  // 0 to 3 idle cycles, returns just after a rising edge
  task automatic random_stall();
    int n;
    n = rand_below(4);
    repeat (n) begin
      @(posedge clock);
      #1;
    end
  endtask

  //////////////////////////////////////////////////
  // slave memory model
  initial begin : write_slave
    int base;
    int beat;
    int idx;
    logic err;
    logic last;
    logic [DATA_W-1:0] data;
    @(posedge rst_n_i);
    forever begin
      @(posedge clock);
      #1;
      if (io_master_awvalid_o) begin
        random_stall();
        last_awaddr = io_master_awaddr_o;
        last_awlen  = int'(io_master_awlen_o);
        check_val("io_master_awid_o", 32'(AXI_ID), 32'(io_master_awid_o));
        // size code is log2 of the bytes per beat
        check_val("io_master_awsize_o", 32'(DATA_W / 8), 32'(1) << io_master_awsize_o);
        check_val("io_master_awburst_o", 32'h1, 32'(io_master_awburst_o));
        io_master_awready_i = 1'b1;
        @(posedge clock);
        #1;
        io_master_awready_i = 1'b0;
        base = beat_index(last_awaddr);
        beat = 0;
        err  = 1'b0;
        last = 1'b0;
        while (!last) begin
          while (!io_master_wvalid_o) begin
            @(posedge clock);
            #1;
          end
          random_stall();
          last = io_master_wlast_o;
          data = io_master_wdata_o;
          check_val("io_master_wlast_o", 32'(beat == last_awlen), 32'(last));
          check_val("io_master_wstrb_o", 32'((1 << (DATA_W / 8)) - 1), 32'(io_master_wstrb_o));
          io_master_wready_i = 1'b1;
          @(posedge clock);
          #1;
          io_master_wready_i = 1'b0;
          idx = base + beat;
          if (idx >= ERR_BASE) begin
            err = 1'b1;
          end else begin
            slv_mem[idx[5:0]] = data;
          end
          beat++;
        end
        check_val("write beat count", 32'(last_awlen + 1), 32'(beat));
        random_stall();
        io_master_bresp_i  = err ? axi_rw_pkg::RESP_SLVERR : axi_rw_pkg::RESP_OKAY;
        io_master_bvalid_i = 1'b1;
        while (!io_master_bready_o) begin
          @(posedge clock);
          #1;
        end
        @(posedge clock);
        #1;
        io_master_bvalid_i = 1'b0;
      end
    end
  end

  initial begin : read_slave
    int base;
    int idx;
    @(posedge rst_n_i);
    forever begin
      @(posedge clock);
      #1;
      if (io_master_arvalid_o) begin
        random_stall();
        last_araddr = io_master_araddr_o;
        last_arlen  = int'(io_master_arlen_o);
        check_val("io_master_arid_o", 32'(AXI_ID), 32'(io_master_arid_o));
        check_val("io_master_arsize_o", 32'(DATA_W / 8), 32'(1) << io_master_arsize_o);
        check_val("io_master_arburst_o", 32'h1, 32'(io_master_arburst_o));
        io_master_arready_i = 1'b1;
        @(posedge clock);
        #1;
        io_master_arready_i = 1'b0;
        base = beat_index(last_araddr);
        for (int i = 0; i <= last_arlen; i++) begin
          random_stall();
          idx = base + i;
          io_master_rdata_i  = slv_mem[idx[5:0]];
          io_master_rresp_i  = (idx >= ERR_BASE) ? axi_rw_pkg::RESP_SLVERR
                                                 : axi_rw_pkg::RESP_OKAY;
          io_master_rlast_i  = (i == last_arlen);
          io_master_rvalid_i = 1'b1;
          while (!io_master_rready_o) begin
            @(posedge clock);
            #1;
          end
          @(posedge clock);
          #1;
          io_master_rvalid_i = 1'b0;
          io_master_rlast_i  = 1'b0;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // one user request, checked against the line model
  task automatic run_request(input axi_rw_pkg::req_op_e op, input int line, input int blks,
                             input line_t wdata);
    int                    len;
    line_t                 exp_line;
    axi_rw_pkg::axi_resp_e exp_resp;
    len      = (blks > BEATS - 1) ? BEATS - 1 : blks;
    exp_resp = (line >= ERR_LINE) ? axi_rw_pkg::RESP_SLVERR : axi_rw_pkg::RESP_OKAY;
    exp_line = '0;
    for (int b = 0; b <= len; b++) begin
      exp_line[b*DATA_W +: DATA_W] = ref_mem[line[3:0]][b*DATA_W +: DATA_W];
    end
    last_awaddr  = '1;
    last_araddr  = '1;
    user_op_i    = op;
    user_addr_i  = 32'(line * LINE_BYTES);
    user_blks_i  = 8'(blks);
    user_wdata_i = wdata;
    user_valid_i = 1'b1;
    n_req++;
    @(posedge clock);
    #1;
    while (!user_ready_o) begin
      @(posedge clock);
      #1;
    end
    user_valid_i = 1'b0;
    check_resp("user_resp_o", exp_resp, user_resp_o);
    if (op == axi_rw_pkg::REQ_READ) begin
      check_line("user_rdata_o", exp_line, user_rdata_o);
      check_val("io_master_araddr_o", 32'(line * LINE_BYTES), last_araddr);
      check_val("io_master_arlen_o", 32'(len), 32'(last_arlen));
    end else begin
      check_val("io_master_awaddr_o", 32'(line * LINE_BYTES), last_awaddr);
      check_val("io_master_awlen_o", 32'(len), 32'(last_awlen));
      if (exp_resp == axi_rw_pkg::RESP_OKAY) begin
        for (int b = 0; b <= len; b++) begin
          ref_mem[line[3:0]][b*DATA_W +: DATA_W] = wdata[b*DATA_W +: DATA_W];
        end
      end
    end
    @(posedge clock);
    #1;
    check_val("user_ready_o", 32'h0, 32'(user_ready_o));
    if (op == axi_rw_pkg::REQ_READ) begin
      check_line("user_rdata_o", exp_line, user_rdata_o);
    end
  endtask

  initial begin : main
    int    line;
    line_t wdata;
    rst_n_i             = 1'b0;
    user_valid_i        = 1'b0;
    user_op_i           = axi_rw_pkg::REQ_READ;
    user_addr_i         = '0;
    user_blks_i         = '0;
    user_wdata_i        = '0;
    io_master_awready_i = 1'b0;
    io_master_wready_i  = 1'b0;
    io_master_bvalid_i  = 1'b0;
    io_master_bresp_i   = '0;
    io_master_arready_i = 1'b0;
    io_master_rvalid_i  = 1'b0;
    io_master_rresp_i   = '0;
    io_master_rdata_i   = '0;
    io_master_rlast_i   = 1'b0;
    for (int a = 0; a < MEM_BEATS; a++) begin
      slv_mem[a[5:0]] = '0;
    end
    for (int l = 0; l < N_LINES; l++) begin
      ref_mem[l[3:0]] = '0;
    end
    repeat (8) @(posedge clock);
    #1;
    rst_n_i = 1'b1;

    for (int c = 0; c < 4; c++) begin
      @(posedge clock);
      #1;
      check_val("idle outputs", 32'h0, 32'({io_master_awvalid_o, io_master_wvalid_o,
                io_master_arvalid_o, io_master_bready_o, io_master_rready_o, user_ready_o}));
    end
    report_test("idle after reset");

    for (int p = 0; p < N_PAIRS; p++) begin
      line = rand_below(ERR_LINE);
      for (int k = 0; k < LINE_W / 32; k++) begin
        wdata[k*32 +: 32] = $random(seed);
      end
      run_request(axi_rw_pkg::REQ_WRITE, line, rand_below(8), wdata);
      run_request(axi_rw_pkg::REQ_READ, line, rand_below(8), '0);
    end
    report_test("random write read");

    // error region, writes must not land
    for (int l = ERR_LINE; l < N_LINES; l++) begin
      for (int k = 0; k < LINE_W / 32; k++) begin
        wdata[k*32 +: 32] = $random(seed);
      end
      run_request(axi_rw_pkg::REQ_WRITE, l, BEATS - 1, wdata);
      run_request(axi_rw_pkg::REQ_READ, l, BEATS - 1, '0);
    end
    report_test("slverr region");

    check_val("user_ready_o pulses", 32'(n_req), 32'(n_pulses));
    report_test("completion pulses");

    n_errors += int'(dut_i.sva_i.fail_cnt);
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    #((N_REQ * 40 + 8 + 8) * 20);
    $display("watchdog expired before all requests completed");
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire
